//--- dv/cop_tb.sv
// Self-checking testbench; needs a simulator with timing support, inputs change 1 ns after posedge
`timescale 1ns/1ps
`include "cop_defs.svh"

module cop_tb;

    localparam logic [31:0] seed       = 32'hd843_ed55;
    localparam int          n_insn     = 176;               // Sum of all phases
    localparam int          max_cycles = 40 * n_insn + 100;

    logic                 g_clk = 1'b0;
    logic                 g_resetn;
    logic                 cpu_insn_req;
    logic [`COP_XLEN-1:0] cpu_insn_enc;
    logic [`COP_XLEN-1:0] cpu_rs1;
    logic                 cpu_insn_ack;
    logic                 cop_insn_ack;
    logic                 cop_insn_rsp;
    logic [2:0]           cop_result;
    logic                 cop_wen;
    logic [4:0]           cop_waddr;
    logic [`COP_XLEN-1:0] cop_wdata;
    logic                 trace_valid;
    cop_pkg::cop_trace_s  trace_rec;

    logic [`COP_XLEN-1:0] model [`COP_NCPR];  // Reference CPR file
    logic [63:0]          acc_q [$];          // {enc, rs1} in accept order
    logic [63:0]          ent;
    cop_pkg::cop_trace_s  exp_now;
    cop_pkg::cop_trace_s  exp_trace;          // Expected record for next trace pulse
    logic                 fire_now;
    logic                 fire_d;
    logic                 hold_d;             // Response waited last cycle
    logic [`COP_XLEN-1:0] held_wdata;
    logic [8:0]           held_ctl;
    logic                 acc_d1;
    logic                 acc_d2;
    logic                 lat_check;          // Fixed latency expected
    logic                 ack_random;
    logic [31:0]          rng;
    int                   cycles = 0;

    always #4 g_clk = ~g_clk;

    cop_top i_cop_top (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cpu_insn_enc (cpu_insn_enc),
        .cpu_rs1      (cpu_rs1),
        .cpu_insn_ack (cpu_insn_ack),
        .cop_insn_ack (cop_insn_ack),
        .cop_insn_rsp (cop_insn_rsp),
        .cop_result   (cop_result),
        .cop_wen      (cop_wen),
        .cop_waddr    (cop_waddr),
        .cop_wdata    (cop_wdata),
        .trace_valid  (trace_valid),
        .trace_rec    (trace_rec)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                                      $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng = xorshift32(rng);
        r   = rng;
    endtask

    function automatic logic [31:0] reg_form(input logic [3:0] op, input logic [3:0] rd,
                                             input logic [3:0] ra, input logic [3:0] rb,
                                             input logic [4:0] dst);
        return {11'h000, dst, rb, ra, rd, op};
    endfunction

    function automatic logic [31:0] imm_form(input logic [3:0] op, input logic [3:0] rd,
                                             input logic [15:0] imm);
        return {imm, 8'h00, rd, op};
    endfunction

    function automatic logic [31:0] random_insn(input logic [31:0] r, input logic alu_only);
        logic [3:0] op;
        case (r[2:0])
            3'd0, 3'd5: op = cop_pkg::OP_ADD;
            3'd1, 3'd6: op = cop_pkg::OP_XOR;
            3'd2, 3'd7: op = cop_pkg::OP_ROTL;
            3'd3:       op = alu_only ? cop_pkg::OP_ADD : cop_pkg::OP_MVC;
            default:    op = alu_only ? cop_pkg::OP_XOR : cop_pkg::OP_LDI;
        endcase
        if (op == cop_pkg::OP_LDI) begin
            return imm_form(op, r[7:4], r[31:16]);
        end
        return reg_form(op, r[7:4], r[11:8], r[15:12], r[20:16]);
    endfunction

    // Expected response and trace fields for one instruction
    function automatic cop_pkg::cop_trace_s expect_result(input logic [31:0] enc,
                                                          input logic [31:0] rs1,
                                                          input logic [31:0] cpr [`COP_NCPR]);
        cop_pkg::cop_trace_s e;
        logic [3:0]          rd;
        logic [31:0]         a;
        logic [31:0]         b;
        logic [4:0]          sh;
        rd = enc[7:4];
        a  = cpr[enc[11:8]];
        b  = cpr[enc[15:12]];
        sh = b[4:0];                       // Rotate amount
        e         = '0;
        e.insn    = enc;
        e.rs1     = rs1;
        e.result  = cop_pkg::RES_OK;
        e.cpr_idx = rd;
        e.cpr_old = cpr[rd];
        e.cpr_new = cpr[rd];               // No change unless written
        case (enc[3:0])
            cop_pkg::OP_ADD: begin
                e.cpr_wen = 1'b1;
                e.cpr_new = a + b;
            end
            cop_pkg::OP_XOR: begin
                e.cpr_wen = 1'b1;
                e.cpr_new = a ^ b;
            end
            cop_pkg::OP_ROTL: begin
                e.cpr_wen = 1'b1;
                e.cpr_new = (sh == 5'd0) ? a : ((a << sh) | (a >> (6'd32 - {1'b0, sh})));
            end
            cop_pkg::OP_MVC: begin
                e.wen   = 1'b1;
                e.waddr = enc[20:16];
                e.wdata = a;
            end
            cop_pkg::OP_LDI: begin
                e.cpr_wen = 1'b1;
                e.cpr_new = rs1 ^ {16'h0000, enc[31:16]};
            end
            default: e.result = cop_pkg::RES_BADOP;
        endcase
        return e;
    endfunction

    // Hold req until the ack cycle, then drop it for gap cycles
    task automatic send(input logic [31:0] enc, input logic [31:0] rs1, input int gap);
        cpu_insn_req = 1'b1;
        cpu_insn_enc = enc;
        cpu_rs1      = rs1;
        do begin
            @(negedge g_clk);
        end while (!cop_insn_ack);
        @(posedge g_clk);
        #1;
        cpu_insn_req = 1'b0;
        repeat (gap) begin
            @(posedge g_clk);
            #1;
        end
    endtask

    task automatic read_all_cprs();
        logic [31:0] r;
        for (int i = 0; i < `COP_NCPR; i++) begin
            draw_random(r);
            send(reg_form(cop_pkg::OP_MVC, r[3:0], 4'(i), r[7:4], r[12:8]), r, 0);
        end
    endtask

    task automatic wait_idle();
        do begin
            @(posedge g_clk);
        end while (acc_q.size() != 0);
        @(posedge g_clk);                  // Let the last trace pulse through
        #1;
    endtask

    // ------------------------------
    // Clock-related processes
    // ------------------------------
    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            stop_with_error($sformatf("Timeout after %0d cycles", cycles));
        end
    end

    // Response acknowledge, random or held high
    initial begin
        logic [31:0] ack_rng;
        logic        mode;
        cpu_insn_ack = 1'b1;
        ack_rng      = ~seed;
        forever begin
            @(posedge g_clk);
            mode = ack_random;             // Sampled before main changes it
            #1;
            ack_rng      = xorshift32(ack_rng);
            cpu_insn_ack = mode ? (ack_rng[7:6] != 2'b00) : 1'b1;
        end
    end

    // ------------------------------
    // Compare process
    // ------------------------------
    always @(negedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < `COP_NCPR; i++) begin
                model[i] = '0;             // CPRs clear in reset
            end
            acc_q.delete();
            fire_d = 1'b0;
            hold_d = 1'b0;
            acc_d1 = 1'b0;
            acc_d2 = 1'b0;
            if (cycles > 0) begin
                check_value("cop_insn_ack in reset", 32'(cop_insn_ack), 32'd0);
                check_value("cop_insn_rsp in reset", 32'(cop_insn_rsp), 32'd0);
                check_value("cop_wen in reset", 32'(cop_wen), 32'd0);
                check_value("trace_valid in reset", 32'(trace_valid), 32'd0);
            end
        end else begin
            // Trace one cycle behind the completed response
            check_value("trace_valid", 32'(trace_valid), 32'(fire_d));
            if (fire_d) begin
                check_value("trace insn", trace_rec.insn, exp_trace.insn);
                check_value("trace rs1", trace_rec.rs1, exp_trace.rs1);
                check_value("trace result", 32'(trace_rec.result), 32'(exp_trace.result));
                check_value("trace cpr_wen", 32'(trace_rec.cpr_wen), 32'(exp_trace.cpr_wen));
                check_value("trace cpr_idx", 32'(trace_rec.cpr_idx), 32'(exp_trace.cpr_idx));
                check_value("trace cpr_old", trace_rec.cpr_old, exp_trace.cpr_old);
                check_value("trace cpr_new", trace_rec.cpr_new, exp_trace.cpr_new);
                check_value("trace wen", 32'(trace_rec.wen), 32'(exp_trace.wen));
                check_value("trace waddr", 32'(trace_rec.waddr), 32'(exp_trace.waddr));
                check_value("trace wdata", trace_rec.wdata, exp_trace.wdata);
            end
            if (hold_d) begin              // Unacked response must not move
                check_value("cop_insn_rsp while held", 32'(cop_insn_rsp), 32'd1);
                check_value("held cop_wdata", cop_wdata, held_wdata);
                check_value("held result/wen/waddr",
                            32'({cop_result, cop_wen, cop_waddr}), 32'(held_ctl));
            end
            if (lat_check && acc_d2) begin
                check_value("cop_insn_rsp two cycles after accept", 32'(cop_insn_rsp), 32'd1);
            end
            if (!cop_insn_rsp) begin
                check_value("cop_wen without response", 32'(cop_wen), 32'd0);
            end
            fire_now = cop_insn_rsp && cpu_insn_ack;
            if (fire_now) begin
                if (acc_q.size() == 0) begin
                    stop_with_error("A response arrived with no instruction outstanding");
                end
                ent     = acc_q.pop_front();
                exp_now = expect_result(ent[63:32], ent[31:0], model);
                check_value("cop_result", 32'(cop_result), 32'(exp_now.result));
                check_value("cop_wen", 32'(cop_wen), 32'(exp_now.wen));
                check_value("cop_waddr", 32'(cop_waddr), 32'(exp_now.waddr));
                check_value("cop_wdata", cop_wdata, exp_now.wdata);
                if (exp_now.cpr_wen) begin
                    model[exp_now.cpr_idx] = exp_now.cpr_new;
                end
                exp_trace = exp_now;
            end
            hold_d     = cop_insn_rsp && !cpu_insn_ack;
            held_wdata = cop_wdata;
            held_ctl   = {cop_result, cop_wen, cop_waddr};
            fire_d     = fire_now;
            acc_d2     = acc_d1;
            acc_d1     = cpu_insn_req && cop_insn_ack;  // Transfer at next edge
            if (acc_d1) begin
                acc_q.push_back({cpu_insn_enc, cpu_rs1});
            end
            if (acc_q.size() > 2) begin
                stop_with_error("More than two instructions are outstanding");
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] t;
        logic [3:0]  bad;
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1      = '0;
        ack_random   = 1'b0;
        lat_check    = 1'b0;
        rng          = seed;
        repeat (2) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;

        // Directed ldi to each CPR, read back with mvc
        for (int i = 0; i < `COP_NCPR; i++) begin
            draw_random(r);
            draw_random(s);
            send(imm_form(cop_pkg::OP_LDI, 4'(i), r[15:0]), s, 0);
        end
        read_all_cprs();

        // Random ALU sequence
        for (int i = 0; i < 48; i++) begin
            draw_random(r);
            draw_random(s);
            send(random_insn(r, 1'b1), s, 0);
        end
        read_all_cprs();

        // Undefined opcodes, then mvc of the named rd
        for (int i = 0; i < 8; i++) begin
            draw_random(r);
            draw_random(s);
            bad = 4'(4 + int'(r[7:0]) % 11);
            if (bad >= 4'd8) begin
                bad = bad + 4'd1;          // Skip ldi
            end
            send({r[31:4], bad}, s, 0);
            send(reg_form(cop_pkg::OP_MVC, 4'd0, r[7:4], 4'd0, 5'(i)), s, 0);
        end

        // Back-to-back with ack held high
        wait_idle();
        lat_check = 1'b1;
        for (int i = 0; i < 24; i++) begin
            draw_random(r);
            draw_random(s);
            send(random_insn(r, 1'b0), s, 0);
        end
        wait_idle();
        lat_check = 1'b0;

        // Random back-pressure and request gaps
        ack_random = 1'b1;
        for (int i = 0; i < 40; i++) begin
            draw_random(r);
            draw_random(s);
            draw_random(t);
            send(random_insn(r, 1'b0), s, int'(t[1:0]));
        end
        wait_idle();
        ack_random = 1'b0;
        wait_idle();

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+verilog
verilog/cop_pkg.sv
verilog/cop_decode.sv
verilog/cop_execute.sv
verilog/cop_trace.sv
verilog/cop_top.sv
dv/cop_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it into a log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module cop_tb \
    -Mdir obj_dir -o cop_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cop_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# The log decides the verdict
if grep -q "Test failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation passed"
exit 0

//--- verilog/cop_decode.sv
// CPU must hold enc and rs1 while req is high and ack low; ack stays low one cycle past reset
`timescale 1ns/1ps
`include "cop_defs.svh"

module cop_decode (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 cpu_insn_req,  // Instruction request
    input  logic [`COP_XLEN-1:0] cpu_insn_enc,  // Encoded instruction
    input  logic [`COP_XLEN-1:0] cpu_rs1,       // RS1 source data
    input  logic                 exe_ready,     // Execute can take dec_op
    output logic                 cop_insn_ack,
    output logic                 dec_valid,
    output cop_pkg::cop_op_s     dec_op
);

    cop_pkg::cop_insn_u insn;    // Both views of the word
    cop_pkg::cop_op_s   op_d;
    logic               run_q;   // Low through reset
    logic               accept;

    assign insn         = cpu_insn_enc;
    assign cop_insn_ack = run_q && (!dec_valid || exe_ready); // Empty or draining
    assign accept       = cpu_insn_req && cop_insn_ack;

    // ------------------------------
    // Field extraction
    // ------------------------------
    always_comb begin
        op_d      = '0;
        op_d.op   = insn.r.opcode;
        op_d.rd   = insn.r.rd;       // Same place in both forms
        op_d.insn = cpu_insn_enc;
        op_d.rs1  = cpu_rs1;
        if (insn.r.opcode[3]) begin  // Immediate form
            op_d.imm = insn.i.imm;
        end else begin
            op_d.rs_a    = insn.r.rs_a;
            op_d.rs_b    = insn.r.rs_b;
            op_d.gpr_dst = insn.r.gpr_dst;
        end
        case (insn.r.opcode)
            cop_pkg::OP_ADD, cop_pkg::OP_XOR, cop_pkg::OP_ROTL,
            cop_pkg::OP_MVC, cop_pkg::OP_LDI: op_d.bad = 1'b0;
            default:                          op_d.bad = 1'b1;
        endcase
    end

    // Control state
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            run_q     <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (accept) begin
                dec_valid <= 1'b1;
            end else if (exe_ready) begin
                dec_valid <= 1'b0;     // Taken by execute
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            dec_op <= op_d;
        end
    end

    // Checks
    a_no_valid_in_reset: assert property (@(posedge g_clk) !g_resetn |=> !dec_valid);

    a_hold_when_stalled: assert property (@(posedge g_clk) disable iff (!g_resetn)
        dec_valid && !exe_ready |=> dec_valid && $stable(dec_op));

endmodule

//--- verilog/cop_defs.svh
// Sizes shared by package and RTL; CPR index width must cover the CPR count
`ifndef COP_DEFS_SVH
`define COP_DEFS_SVH

// ------------------------------
// Datapath sizes
// ------------------------------

// Data and instruction word width
`define COP_XLEN   32

// Number of coprocessor registers
`define COP_NCPR   16

// CPR index width, log2 of COP_NCPR
`define COP_CPR_AW 4

`endif

//--- verilog/cop_execute.sv
// One op per cycle; a new op is taken only when the pending response completes the same cycle
`timescale 1ns/1ps
`include "cop_defs.svh"

module cop_execute (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 dec_valid,
    input  cop_pkg::cop_op_s     dec_op,
    input  logic                 cpu_insn_ack,  // Response acknowledge
    output logic                 exe_ready,
    output logic                 cop_insn_rsp,  // Response pending
    output logic [2:0]           cop_result,
    output logic                 cop_wen,
    output logic [4:0]           cop_waddr,
    output logic [`COP_XLEN-1:0] cop_wdata,
    output logic                 rsp_fire,      // rsp and ack this cycle
    output cop_pkg::cop_rsp_s    rsp_rec
);

    logic [`COP_XLEN-1:0]   cprs [`COP_NCPR];
    logic [`COP_XLEN-1:0]   opa;
    logic [`COP_XLEN-1:0]   opb;
    logic [2*`COP_XLEN-1:0] rot_w;   // Doubled word for rotate
    cop_pkg::cop_rsp_s      rsp_d;
    cop_pkg::cop_rsp_s      rsp_q;
    logic                   exe_fire;

    assign rsp_fire  = cop_insn_rsp && cpu_insn_ack;
    assign exe_ready = !cop_insn_rsp || cpu_insn_ack;
    assign exe_fire  = dec_valid && exe_ready;

    assign opa   = cprs[dec_op.rs_a];
    assign opb   = cprs[dec_op.rs_b];
    assign rot_w = {opa, opa} << opb[4:0];

    // ------------------------------
    // Operation
    // ------------------------------
    always_comb begin
        rsp_d         = '0;
        rsp_d.result  = cop_pkg::RES_OK;
        rsp_d.insn    = dec_op.insn;
        rsp_d.rs1     = dec_op.rs1;
        rsp_d.cpr_idx = dec_op.rd;
        rsp_d.cpr_old = cprs[dec_op.rd];
        rsp_d.cpr_new = cprs[dec_op.rd];  // Unchanged unless written
        if (dec_op.bad) begin
            rsp_d.result = cop_pkg::RES_BADOP;
        end else begin
            case (dec_op.op)
                cop_pkg::OP_ADD: begin
                    rsp_d.cpr_wen = 1'b1;
                    rsp_d.cpr_new = opa + opb;
                end
                cop_pkg::OP_XOR: begin
                    rsp_d.cpr_wen = 1'b1;
                    rsp_d.cpr_new = opa ^ opb;
                end
                cop_pkg::OP_ROTL: begin
                    rsp_d.cpr_wen = 1'b1;
                    rsp_d.cpr_new = rot_w[2*`COP_XLEN-1:`COP_XLEN];
                end
                cop_pkg::OP_MVC: begin             // Read out to CPU
                    rsp_d.wen   = 1'b1;
                    rsp_d.waddr = dec_op.gpr_dst;
                    rsp_d.wdata = opa;
                end
                cop_pkg::OP_LDI: begin
                    rsp_d.cpr_wen = 1'b1;
                    rsp_d.cpr_new = dec_op.rs1 ^ {{(`COP_XLEN-16){1'b0}}, dec_op.imm};
                end
                default: rsp_d.result = cop_pkg::RES_BADOP;
            endcase
        end
    end

    // CPR file and response flag
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < `COP_NCPR; i++) begin
                cprs[i] <= '0;
            end
            cop_insn_rsp <= 1'b0;
        end else begin
            if (exe_fire && rsp_d.cpr_wen) begin
                cprs[rsp_d.cpr_idx] <= rsp_d.cpr_new;
            end
            if (exe_fire) begin
                cop_insn_rsp <= 1'b1;
            end else if (cpu_insn_ack) begin
                cop_insn_rsp <= 1'b0;  // Completed
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (exe_fire) begin
            rsp_q <= rsp_d;
        end
    end

    assign cop_result = rsp_q.result;
    assign cop_wen    = cop_insn_rsp && rsp_q.wen;  // Only with a live response
    assign cop_waddr  = rsp_q.waddr;
    assign cop_wdata  = rsp_q.wdata;
    assign rsp_rec    = rsp_q;

    a_rsp_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cop_insn_rsp && !cpu_insn_ack |=> cop_insn_rsp && $stable(rsp_q));

endmodule

//--- verilog/cop_pkg.sv
// Opcodes live in insn[3:0], bit 3 marks the immediate form; only five opcodes are legal
`include "cop_defs.svh"

package cop_pkg;

    // ------------------------------
    // Opcodes and result codes
    // ------------------------------
    localparam logic [3:0] OP_ADD  = 4'h0; // cpr[rd] = cpr[a] + cpr[b]
    localparam logic [3:0] OP_XOR  = 4'h1; // cpr[rd] = cpr[a] ^ cpr[b]
    localparam logic [3:0] OP_ROTL = 4'h2; // Rotate left by cpr[b][4:0]
    localparam logic [3:0] OP_MVC  = 4'h3; // gpr[dst] = cpr[a]
    localparam logic [3:0] OP_LDI  = 4'h8; // cpr[rd] = rs1 ^ imm

    localparam logic [2:0] RES_OK    = 3'd0;
    localparam logic [2:0] RES_BADOP = 3'd1;

    // ------------------------------
    // Instruction word views
    // ------------------------------
    typedef struct packed {
        logic [10:0] unused;
        logic [4:0]  gpr_dst; // CPU register for mvc
        logic [3:0]  rs_b;
        logic [3:0]  rs_a;
        logic [3:0]  rd;
        logic [3:0]  opcode;
    } cop_rform_s;

    typedef struct packed {
        logic [15:0] imm;     // Zero-extended on use
        logic [7:0]  unused;
        logic [3:0]  rd;
        logic [3:0]  opcode;
    } cop_iform_s;

    typedef union packed {
        cop_rform_s r;
        cop_iform_s i;
    } cop_insn_u;

    // Decode to execute
    typedef struct packed {
        logic [3:0]             op;
        logic [`COP_CPR_AW-1:0] rd;
        logic [`COP_CPR_AW-1:0] rs_a;
        logic [`COP_CPR_AW-1:0] rs_b;
        logic [4:0]             gpr_dst;
        logic [15:0]            imm;
        logic                   bad;     // Undefined opcode
        logic [`COP_XLEN-1:0]   insn;    // Raw encoding, kept for trace
        logic [`COP_XLEN-1:0]   rs1;
    } cop_op_s;

    // Execute to capture
    typedef struct packed {
        logic [2:0]             result;
        logic                   wen;
        logic [4:0]             waddr;
        logic [`COP_XLEN-1:0]   wdata;
        logic                   cpr_wen;
        logic [`COP_CPR_AW-1:0] cpr_idx;
        logic [`COP_XLEN-1:0]   cpr_old;
        logic [`COP_XLEN-1:0]   cpr_new;
        logic [`COP_XLEN-1:0]   insn;
        logic [`COP_XLEN-1:0]   rs1;
    } cop_rsp_s;

    // External trace record, same content as the response for now
    typedef struct packed {
        logic [2:0]             result;
        logic                   wen;
        logic [4:0]             waddr;
        logic [`COP_XLEN-1:0]   wdata;
        logic                   cpr_wen;
        logic [`COP_CPR_AW-1:0] cpr_idx;
        logic [`COP_XLEN-1:0]   cpr_old;
        logic [`COP_XLEN-1:0]   cpr_new;
        logic [`COP_XLEN-1:0]   insn;
        logic [`COP_XLEN-1:0]   rs1;
    } cop_trace_s;

endpackage

//--- verilog/cop_top.sv
// Two-stage coprocessor plus trace capture; cpu_insn_ack feeds back combinationally to cop_insn_ack
`timescale 1ns/1ps
`include "cop_defs.svh"

module cop_top (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 cpu_insn_req,  // Instruction request
    input  logic [`COP_XLEN-1:0] cpu_insn_enc,
    input  logic [`COP_XLEN-1:0] cpu_rs1,
    input  logic                 cpu_insn_ack,  // Response acknowledge
    output logic                 cop_insn_ack,
    output logic                 cop_insn_rsp,
    output logic [2:0]           cop_result,
    output logic                 cop_wen,
    output logic [4:0]           cop_waddr,
    output logic [`COP_XLEN-1:0] cop_wdata,
    output logic                 trace_valid,
    output cop_pkg::cop_trace_s  trace_rec
);

    // ------------------------------
    // Stage links
    // ------------------------------
    logic              dec_valid;
    cop_pkg::cop_op_s  dec_op;
    logic              exe_ready;
    logic              rsp_fire;
    cop_pkg::cop_rsp_s rsp_rec;

    cop_decode i_decode (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cpu_insn_enc (cpu_insn_enc),
        .cpu_rs1      (cpu_rs1),
        .exe_ready    (exe_ready),
        .cop_insn_ack (cop_insn_ack),
        .dec_valid    (dec_valid),
        .dec_op       (dec_op)
    );

    cop_execute i_execute (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .dec_valid    (dec_valid),
        .dec_op       (dec_op),
        .cpu_insn_ack (cpu_insn_ack),
        .exe_ready    (exe_ready),
        .cop_insn_rsp (cop_insn_rsp),
        .cop_result   (cop_result),
        .cop_wen      (cop_wen),
        .cop_waddr    (cop_waddr),
        .cop_wdata    (cop_wdata),
        .rsp_fire     (rsp_fire),
        .rsp_rec      (rsp_rec)
    );

    cop_trace i_trace (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .rsp_fire     (rsp_fire),
        .rsp_rec      (rsp_rec),
        .cpu_insn_req (cpu_insn_req),
        .cop_insn_ack (cop_insn_ack),
        .trace_valid  (trace_valid),
        .trace_rec    (trace_rec)
    );

endmodule

//--- verilog/cop_trace.sv
// Observer only, never stalls; at most two instructions may be in flight
`timescale 1ns/1ps

module cop_trace (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  logic                rsp_fire,      // Response completes
    input  cop_pkg::cop_rsp_s   rsp_rec,
    input  logic                cpu_insn_req,
    input  logic                cop_insn_ack,
    output logic                trace_valid,   // One-cycle pulse
    output cop_pkg::cop_trace_s trace_rec
);

    logic [1:0] outstanding;  // Accepted but unanswered
    logic       accept;

    assign accept = cpu_insn_req && cop_insn_ack;

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            trace_valid <= 1'b0;
            outstanding <= 2'd0;
        end else begin
            trace_valid <= rsp_fire;
            if (accept && !rsp_fire) begin
                outstanding <= outstanding + 2'd1;
            end else if (!accept && rsp_fire) begin
                outstanding <= outstanding - 2'd1;
            end
        end
    end

    // Record capture
    always_ff @(posedge g_clk) begin
        if (rsp_fire) begin
            trace_rec.result  <= rsp_rec.result;
            trace_rec.wen     <= rsp_rec.wen;
            trace_rec.waddr   <= rsp_rec.waddr;
            trace_rec.wdata   <= rsp_rec.wdata;
            trace_rec.cpr_wen <= rsp_rec.cpr_wen;
            trace_rec.cpr_idx <= rsp_rec.cpr_idx;
            trace_rec.cpr_old <= rsp_rec.cpr_old;  // Before value
            trace_rec.cpr_new <= rsp_rec.cpr_new;  // After value
            trace_rec.insn    <= rsp_rec.insn;
            trace_rec.rs1     <= rsp_rec.rs1;
        end
    end

    // ------------------------------
    // Handshake rules
    // ------------------------------

    // One in decode, one in execute at most
    a_max_inflight: assert property (@(posedge g_clk) disable iff (!g_resetn)
        outstanding <= 2'd2);

    // Every response answers an earlier request
    a_rsp_has_req: assert property (@(posedge g_clk) disable iff (!g_resetn)
        rsp_fire |-> outstanding != 2'd0);

endmodule
